// ==== design/mma_pkg.sv ====
package mma_pkg;

    // ======================================================================
    // Array geometry and latency
    // ======================================================================
    localparam int LANES        = 4;  // Array width, IA elements per beat
    localparam int ROW_IDX_W    = 2;  // Selects one weight row
    localparam int PIPE_LATENCY = 5;  // Last beat sampled to out_valid

    // ======================================================================
    // Scalar types
    // ======================================================================
    typedef logic signed [7:0]  ia_t;      // Raw IA element
    typedef logic signed [7:0]  weight_t;  // Weight element
    typedef logic signed [16:0] ia_ofs_t;  // IA element with zero point added
    typedef logic signed [31:0] acc_t;     // Accumulator and bias
    typedef logic signed [31:0] quant_t;   // Requant parameters
    typedef logic signed [63:0] prod_t;    // Accumulator times multiplier
    typedef logic signed [7:0]  out_t;     // Requantized output

    // ======================================================================
    // Lane vectors
    // ======================================================================
    // Element i sits at index i of each packed vector
    typedef ia_t         [LANES-1:0] ia_vec_t;
    typedef ia_ofs_t     [LANES-1:0] ia_ofs_vec_t;
    typedef weight_t     [LANES-1:0] weight_row_t;   // Row i, columns 0..3
    typedef weight_row_t [LANES-1:0] weight_tile_t;  // Indexed [row][col]
    typedef acc_t        [LANES-1:0] acc_vec_t;
    typedef out_t        [LANES-1:0] out_vec_t;

endpackage

// ==== design/operand_if.sv ====
interface operand_if;

    logic                  beat_valid;  // One pulse per IA beat
    logic                  beat_last;   // Closes an accumulation group
    mma_pkg::ia_ofs_vec_t  ia_ofs;      // IA beat with zero point applied
    mma_pkg::weight_tile_t tile;        // Held weight tile
    mma_pkg::acc_vec_t     bias;        // Held per-column bias

    // Loader side
    modport source (
        output beat_valid,
        output beat_last,
        output ia_ofs,
        output tile,
        output bias
    );

    // Array side
    modport sink (
        input beat_valid,
        input beat_last,
        input ia_ofs,
        input tile,
        input bias
    );

endinterface

// ==== design/operand_loader.sv ====
module operand_loader (
    input  logic                           clk,
    input  logic                           rst_n,

    // Weight tile, one row per strobe
    input  logic                           weight_load,
    input  logic [mma_pkg::ROW_IDX_W-1:0]  weight_row_idx,
    input  mma_pkg::weight_row_t           weight_row,

    // Per-column bias, all lanes at once
    input  logic                           bias_load,
    input  mma_pkg::acc_vec_t              bias_vec,

    // IA stream
    input  logic                           ia_valid,
    input  logic                           ia_last,
    input  mma_pkg::ia_vec_t               ia_vec,
    input  mma_pkg::quant_t                lhs_zp,

    operand_if.source                      op
);

    // ======================================================================
    // Tile and bias storage
    // ======================================================================
    // Both start from zero so early groups see an empty tile
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op.tile <= '0;
            op.bias <= '0;
        end else begin
            if (weight_load) begin
                op.tile[weight_row_idx] <= weight_row;  // Single row write
            end
            if (bias_load) begin
                op.bias <= bias_vec;
            end
        end
    end

    // ======================================================================
    // IA beat register
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op.beat_valid <= 1'b0;
            op.beat_last  <= 1'b0;
        end else begin
            op.beat_valid <= ia_valid;
            op.beat_last  <= ia_valid & ia_last;  // Only meaningful with a beat
        end
    end

    // Zero point added per element, kept to 17 bits
    always_ff @(posedge clk) begin
        if (ia_valid) begin
            for (int i = 0; i < mma_pkg::LANES; i++) begin
                op.ia_ofs[i] <= mma_pkg::ia_ofs_t'($signed(ia_vec[i]) + lhs_zp);
            end
        end
    end

endmodule

// ==== design/mac_array.sv ====
module mac_array (
    input  logic              clk,
    input  logic              rst_n,

    operand_if.sink           op,

    output logic              acc_valid,  // One pulse per finished group
    output mma_pkg::acc_vec_t acc_vec     // Group total plus bias
);

    mma_pkg::acc_vec_t beat_sum;   // Column sums of the current beat
    mma_pkg::acc_vec_t prod_sum;   // Registered column sums
    logic              prod_valid;
    logic              prod_last;
    mma_pkg::acc_vec_t acc;        // Running per-column totals

    // ======================================================================
    // Product stage
    // ======================================================================
    // Column j collects ia_ofs[i] * tile[i][j] over all rows i
    always_comb begin
        beat_sum = '0;
        for (int j = 0; j < mma_pkg::LANES; j++) begin
            for (int i = 0; i < mma_pkg::LANES; i++) begin
                beat_sum[j] = beat_sum[j]
                            + mma_pkg::acc_t'($signed(op.ia_ofs[i])
                                              * $signed(op.tile[i][j]));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
            prod_last  <= 1'b0;
        end else begin
            prod_valid <= op.beat_valid;
            prod_last  <= op.beat_valid & op.beat_last;
        end
    end

    always_ff @(posedge clk) begin
        if (op.beat_valid) begin
            prod_sum <= beat_sum;
        end
    end

    // ======================================================================
    // Accumulate stage
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc       <= '0;
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= prod_valid & prod_last;
            if (prod_valid) begin
                // Last beat hands the total out and restarts from zero
                if (prod_last) begin
                    acc <= '0;
                end else begin
                    for (int j = 0; j < mma_pkg::LANES; j++) begin
                        acc[j] <= $signed(acc[j]) + $signed(prod_sum[j]);
                    end
                end
            end
        end
    end

    // Result register, 32-bit wraparound
    always_ff @(posedge clk) begin
        if (prod_valid && prod_last) begin
            for (int j = 0; j < mma_pkg::LANES; j++) begin
                acc_vec[j] <= $signed(acc[j]) + $signed(prod_sum[j])
                            + $signed(op.bias[j]);
            end
        end
    end

endmodule

// ==== design/requant_unit.sv ====
module requant_unit (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              acc_valid,
    input  mma_pkg::acc_vec_t acc_vec,

    // Per-tensor quantization, held static during a run
    input  mma_pkg::quant_t   q_mult,
    input  mma_pkg::quant_t   q_shift,   // 0..31
    input  mma_pkg::quant_t   dst_zp,
    input  mma_pkg::quant_t   act_min,
    input  mma_pkg::quant_t   act_max,

    output logic              out_valid,
    output mma_pkg::out_vec_t out_vec
);

    mma_pkg::prod_t   mult_q [mma_pkg::LANES];  // Stage one products
    logic             mult_valid;
    logic [5:0]       rnd_pos;                  // Position of the rounding bit
    logic [5:0]       shift_amt;
    mma_pkg::out_vec_t clamped;

    // ======================================================================
    // Stage one: multiply
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mult_valid <= 1'b0;
        end else begin
            mult_valid <= acc_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (acc_valid) begin
            for (int j = 0; j < mma_pkg::LANES; j++) begin
                mult_q[j] <= mma_pkg::prod_t'($signed(acc_vec[j]) * q_mult);
            end
        end
    end

    // ======================================================================
    // Stage two: round, shift, offset, clamp
    // ======================================================================
    assign rnd_pos   = 6'd30 + {1'b0, q_shift[4:0]};
    assign shift_amt = 6'd31 + {1'b0, q_shift[4:0]};

    always_comb begin
        mma_pkg::prod_t rounded;
        mma_pkg::acc_t  val;
        for (int j = 0; j < mma_pkg::LANES; j++) begin
            rounded = (mult_q[j] + (mma_pkg::prod_t'(1) << rnd_pos)) >>> shift_amt;
            val     = mma_pkg::acc_t'(rounded) + dst_zp;  // Low 32 bits plus zero point
            if (val < act_min) begin
                val = act_min;
            end
            if (val > act_max) begin
                val = act_max;
            end
            clamped[j] = val[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= mult_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mult_valid) begin
            out_vec <= clamped;
        end
    end

endmodule

// ==== design/mma_top.sv ====
module mma_top (
    input  logic                          clk,
    input  logic                          rst_n,

    // Weight tile rows
    input  logic                          weight_load,
    input  logic [mma_pkg::ROW_IDX_W-1:0] weight_row_idx,
    input  mma_pkg::weight_row_t          weight_row,

    // Bias
    input  logic                          bias_load,
    input  mma_pkg::acc_vec_t             bias_vec,

    // IA stream
    input  logic                          ia_valid,
    input  logic                          ia_last,
    input  mma_pkg::ia_vec_t              ia_vec,

    // Static quantization levels
    input  mma_pkg::quant_t               lhs_zp,
    input  mma_pkg::quant_t               q_mult,
    input  mma_pkg::quant_t               q_shift,
    input  mma_pkg::quant_t               dst_zp,
    input  mma_pkg::quant_t               act_min,
    input  mma_pkg::quant_t               act_max,

    // Results, no back-pressure
    output logic                          out_valid,
    output mma_pkg::out_vec_t             out_vec
);

    // ======================================================================
    // Stage interconnect
    // ======================================================================
    operand_if         op_if ();
    logic              acc_valid;
    mma_pkg::acc_vec_t acc_vec;

    operand_loader operand_loader_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .weight_load   (weight_load),
        .weight_row_idx(weight_row_idx),
        .weight_row    (weight_row),
        .bias_load     (bias_load),
        .bias_vec      (bias_vec),
        .ia_valid      (ia_valid),
        .ia_last       (ia_last),
        .ia_vec        (ia_vec),
        .lhs_zp        (lhs_zp),
        .op            (op_if.source)
    );

    mac_array mac_array_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .op       (op_if.sink),
        .acc_valid(acc_valid),
        .acc_vec  (acc_vec)
    );

    // Two cycles from group total to output
    requant_unit requant_unit_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .acc_valid(acc_valid),
        .acc_vec  (acc_vec),
        .q_mult   (q_mult),
        .q_shift  (q_shift),
        .dst_zp   (dst_zp),
        .act_min  (act_min),
        .act_max  (act_max),
        .out_valid(out_valid),
        .out_vec  (out_vec)
    );

endmodule

// ==== test/tb_clock.sv ====
module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    // Free-running clock, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

// ==== test/mma_assert.sv ====
module mma_assert (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ia_valid,
    input  logic              ia_last,
    input  logic              out_valid,
    input  mma_pkg::out_vec_t out_vec,
    input  mma_pkg::quant_t   act_min,
    input  mma_pkg::quant_t   act_max
);

    // ======================================================================
    // Fixed latency in both directions
    // ======================================================================
    assert property (@(posedge clk) disable iff (!rst_n)
        (ia_valid && ia_last) |-> ##(mma_pkg::PIPE_LATENCY) out_valid)
        else $error("out_valid missing %0d cycles after a last beat",
                    mma_pkg::PIPE_LATENCY);

    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(ia_valid && ia_last, mma_pkg::PIPE_LATENCY))
        else $error("out_valid without a last beat %0d cycles earlier",
                    mma_pkg::PIPE_LATENCY);

    assert property (@(posedge clk) !rst_n |=> !out_valid)  // Cleared by reset
        else $error("out_valid high in the cycle after reset");

    // Every lane stays inside the clamp window
    for (genvar j = 0; j < mma_pkg::LANES; j++) begin : g_lane
        assert property (@(posedge clk) disable iff (!rst_n)
            out_valid |-> ($signed(out_vec[j]) >= act_min
                           && $signed(out_vec[j]) <= act_max))
            else $error("out_vec lane %0d outside act_min..act_max", j);
    end

endmodule

bind mma_top mma_assert mma_assert_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .ia_valid (ia_valid),
    .ia_last  (ia_last),
    .out_valid(out_valid),
    .out_vec  (out_vec),
    .act_min  (act_min),
    .act_max  (act_max)
);

// ==== test/mma_tb.sv ====
module mma_tb;

    logic                          clk;
    logic                          rst_n;
    logic                          weight_load;
    logic [mma_pkg::ROW_IDX_W-1:0] weight_row_idx;
    mma_pkg::weight_row_t          weight_row;
    logic                          bias_load;
    mma_pkg::acc_vec_t             bias_vec;
    logic                          ia_valid;
    logic                          ia_last;
    mma_pkg::ia_vec_t              ia_vec;
    mma_pkg::quant_t               lhs_zp;
    mma_pkg::quant_t               q_mult;
    mma_pkg::quant_t               q_shift;
    mma_pkg::quant_t               dst_zp;
    mma_pkg::quant_t               act_min;
    mma_pkg::quant_t               act_max;
    logic                          out_valid;
    mma_pkg::out_vec_t             out_vec;

    // Reference model state
    mma_pkg::weight_tile_t m_tile;
    mma_pkg::acc_vec_t     m_bias;
    int                    m_acc [mma_pkg::LANES];
    int                    m_lhs_zp;
    int                    m_q_mult;
    int                    m_q_shift;
    int                    m_dst_zp;
    int                    m_act_min;
    int                    m_act_max;
    mma_pkg::out_vec_t     expected_q [$];  // Results in flight with the oldest first

    int errors;
    int checks;
    int tests_run;
    int tests_failed;
    int test_err_start;
    int max_in_flight;
    int clamp_lo_hits;
    int clamp_hi_hits;

    tb_clock #(.PERIOD(100)) tb_clock_inst (.clk(clk));

    mma_top mma_top_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .weight_load   (weight_load),
        .weight_row_idx(weight_row_idx),
        .weight_row    (weight_row),
        .bias_load     (bias_load),
        .bias_vec      (bias_vec),
        .ia_valid      (ia_valid),
        .ia_last       (ia_last),
        .ia_vec        (ia_vec),
        .lhs_zp        (lhs_zp),
        .q_mult        (q_mult),
        .q_shift       (q_shift),
        .dst_zp        (dst_zp),
        .act_min       (act_min),
        .act_max       (act_max),
        .out_valid     (out_valid),
        .out_vec       (out_vec)
    );

    // ======================================================================
    // Model arithmetic
    // ======================================================================
    function automatic int rand_between(int lo, int hi);
        return lo + int'($urandom % (hi - lo + 1));
    endfunction

    function automatic int column_sum(mma_pkg::ia_vec_t v, int j);
        int                 s;
        logic signed [16:0] ofs;
        s = 0;
        for (int i = 0; i < mma_pkg::LANES; i++) begin
            ofs = $signed(v[i]) + m_lhs_zp;  // Kept to 17 bits
            s   = s + int'(ofs) * int'($signed(m_tile[i][j]));
        end
        return s;
    endfunction

    function automatic mma_pkg::out_t requant(int total);
        longint prod;
        int     v;
        prod = longint'(total) * longint'(m_q_mult);
        prod = (prod + (longint'(1) << (30 + m_q_shift))) >>> (31 + m_q_shift);
        v    = int'(prod) + m_dst_zp;  // Low 32 bits only
        if (v < m_act_min) begin
            v = m_act_min;
            clamp_lo_hits++;
        end
        if (v > m_act_max) begin
            v = m_act_max;
            clamp_hi_hits++;
        end
        return v[7:0];
    endfunction

    function automatic mma_pkg::ia_vec_t random_ia(int lim);
        mma_pkg::ia_vec_t v;
        for (int i = 0; i < mma_pkg::LANES; i++) begin
            v[i] = mma_pkg::ia_t'(rand_between(-lim, lim));
        end
        return v;
    endfunction

    // ======================================================================
    // Stimulus
    // ======================================================================
    task automatic send_beat(input mma_pkg::ia_vec_t v, input logic last);
        mma_pkg::out_vec_t exp_vec;
        @(posedge clk);
        ia_valid <= 1'b1;
        ia_vec   <= v;
        ia_last  <= last;
        for (int j = 0; j < mma_pkg::LANES; j++) begin
            m_acc[j] = m_acc[j] + column_sum(v, j);
        end
        if (last) begin
            for (int j = 0; j < mma_pkg::LANES; j++) begin
                exp_vec[j] = requant(m_acc[j] + m_bias[j]);
                m_acc[j]   = 0;  // Next group starts clean
            end
            expected_q.push_back(exp_vec);
            if (expected_q.size() > max_in_flight) begin
                max_in_flight = expected_q.size();
            end
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            ia_valid <= 1'b0;
            ia_last  <= 1'b0;
        end
    endtask

    task automatic load_row(input int r, input int lim);
        mma_pkg::weight_row_t row;
        for (int c = 0; c < mma_pkg::LANES; c++) begin
            row[c] = mma_pkg::weight_t'(rand_between(-lim, lim));
        end
        @(posedge clk);
        weight_load    <= 1'b1;
        weight_row_idx <= r[mma_pkg::ROW_IDX_W-1:0];
        weight_row     <= row;
        m_tile[r] = row;
        @(posedge clk);
        weight_load <= 1'b0;
    endtask

    task automatic load_tile(input int lim);
        for (int r = 0; r < mma_pkg::LANES; r++) begin
            load_row(r, lim);
        end
    endtask

    task automatic load_bias(input int lim);
        mma_pkg::acc_vec_t b;
        for (int j = 0; j < mma_pkg::LANES; j++) begin
            b[j] = mma_pkg::acc_t'(rand_between(-lim, lim));
        end
        @(posedge clk);
        bias_load <= 1'b1;
        bias_vec  <= b;
        m_bias = b;
        @(posedge clk);
        bias_load <= 1'b0;
    endtask

    // Only called with nothing in flight
    task automatic set_quant(input int lzp, input int mult, input int sh,
                             input int dzp, input int amin, input int amax);
        @(posedge clk);
        lhs_zp  <= lzp;
        q_mult  <= mult;
        q_shift <= sh;
        dst_zp  <= dzp;
        act_min <= amin;
        act_max <= amax;
        m_lhs_zp  = lzp;
        m_q_mult  = mult;
        m_q_shift = sh;
        m_dst_zp  = dzp;
        m_act_min = amin;
        m_act_max = amax;
    endtask

    task automatic run_groups(input int count, input int max_len, input int max_gap,
                              input int ia_lim);
        int len;
        int gap;
        repeat (count) begin
            len = rand_between(1, max_len);
            for (int b = 0; b < len; b++) begin
                send_beat(random_ia(ia_lim), b == len - 1);
                gap = rand_between(0, max_gap);
                if (gap > 0) begin
                    idle_cycles(gap);
                end
            end
        end
        idle_cycles(1);
    endtask

    task automatic wait_drain;
        int n;
        n = 0;
        while (expected_q.size() > 0 && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (expected_q.size() > 0) begin
            $display("Timeout: %0d expected results never appeared", expected_q.size());
            errors++;
            expected_q.delete();
        end
    endtask

    task automatic end_test(input string name);
        wait_drain();
        tests_run++;
        if (errors > test_err_start) begin
            tests_failed++;
            $display("test %0d %s: FAIL (%0d errors)", tests_run, name,
                     errors - test_err_start);
        end else begin
            $display("test %0d %s: PASS", tests_run, name);
        end
        test_err_start = errors;
    endtask

    // ======================================================================
    // Output checker
    // ======================================================================
    always @(negedge clk) begin : check_outputs
        mma_pkg::out_vec_t exp_vec;
        if (rst_n && out_valid) begin
            checks++;
            assert (expected_q.size() > 0) else begin
                $display("out_valid raised with no result pending");
                errors++;
            end
            if (expected_q.size() > 0) begin
                exp_vec = expected_q.pop_front();
                assert (out_vec == exp_vec) else begin
                    $display("ERR out_vec expected %h actual %h", exp_vec, out_vec);
                    errors++;
                end
            end
        end
    end

    initial begin
        void'($urandom(32'hbc97653f));
        rst_n          = 1'b0;
        weight_load    = 1'b0;
        weight_row_idx = '0;
        weight_row     = '0;
        bias_load      = 1'b0;
        bias_vec       = '0;
        ia_valid       = 1'b0;
        ia_last        = 1'b0;
        ia_vec         = '0;
        lhs_zp         = 0;
        q_mult         = 32'sh4000_0000;  // Neutral scale of one half
        q_shift        = 0;
        dst_zp         = 0;
        act_min        = -128;
        act_max        = 127;
        m_tile         = '0;
        m_bias         = '0;
        m_lhs_zp       = 0;
        m_q_mult       = 32'sh4000_0000;
        m_q_shift      = 0;
        m_dst_zp       = 0;
        m_act_min      = -128;
        m_act_max      = 127;
        foreach (m_acc[j]) m_acc[j] = 0;
        errors         = 0;
        checks         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        test_err_start = 0;
        max_in_flight  = 0;
        clamp_lo_hits  = 0;
        clamp_hi_hits  = 0;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // Zero tile after reset gives the clamped zero point
        idle_cycles(8);
        set_quant(0, 32'sh4000_0000, 0, rand_between(-200, 200), -100, 100);
        run_groups(5, 3, 1, 127);
        end_test("reset state");

        set_quant(0, 32'sh4000_0000, 0, 0, -128, 127);
        load_tile(2);
        load_bias(40);
        max_in_flight = 0;
        run_groups(20, 1, 0, 16);  // One-beat groups back to back
        wait_drain();
        assert (max_in_flight >= mma_pkg::PIPE_LATENCY) else begin
            $display("Fewer results in flight than the pipeline depth");
            errors++;
        end
        end_test("single-beat groups");

        set_quant(0, 32'sh4000_0000, 2, 0, -128, 127);
        load_tile(4);
        run_groups(15, 6, 3, 8);
        end_test("multi-beat groups");

        // Magnitude 1..100 with a random sign
        set_quant(rand_between(1, 100) * (2 * rand_between(0, 1) - 1), 32'sh4000_0000, 2, 0,
                  -128, 127);
        load_tile(2);
        run_groups(12, 4, 2, 16);
        end_test("input zero point");

        clamp_lo_hits = 0;
        clamp_hi_hits = 0;
        load_tile(127);
        repeat (4) begin
            set_quant(0, rand_between(32'sh1000_0000, 32'sh7fff_ffff), rand_between(0, 4),
                      rand_between(-20, 20), rand_between(-60, -5), rand_between(5, 60));
            run_groups(8, 3, 1, 127);
            wait_drain();
        end
        assert (clamp_lo_hits > 0 && clamp_hi_hits > 0) else begin
            $display("Clamping at act_min or act_max never occurred");
            errors++;
        end
        end_test("random requant");

        set_quant(0, 32'sh4000_0000, 3, 0, -128, 127);
        load_tile(8);
        load_bias(200);
        run_groups(6, 4, 2, 32);
        wait_drain();
        load_row(1, 8);
        load_row(3, 8);
        load_bias(200);
        run_groups(6, 4, 2, 32);
        end_test("tile reload");

        assert (checks > 0) else begin
            $display("No results were checked");
            errors++;
        end
        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
design/mma_pkg.sv
design/operand_if.sv
design/operand_loader.sv
design/mac_array.sv
design/requant_unit.sv
design/mma_top.sv
test/tb_clock.sv
test/mma_assert.sv
test/mma_tb.sv
